/* src/dec_params.svh */
`ifndef DEC_PARAMS_SVH
`define DEC_PARAMS_SVH

`define DEC_DATA_W   32
`define DEC_REG_AW   5
`define DEC_NUM_REGS 32
`define DEC_LINK_REG 31     // ra, target of the linking forms

`endif

/* src/dec_pkg.sv */
`include "dec_params.svh"

package dec_pkg;

    typedef logic [`DEC_DATA_W-1:0] word_t;
    typedef logic [`DEC_REG_AW-1:0] reg_addr_t;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000, OP_REGIMM = 6'b000001, OP_J     = 6'b000010,
        OP_JAL     = 6'b000011, OP_BEQ    = 6'b000100, OP_BNE   = 6'b000101,
        OP_BLEZ    = 6'b000110, OP_BGTZ   = 6'b000111, OP_ADDI  = 6'b001000,
        OP_ADDIU   = 6'b001001, OP_SLTI   = 6'b001010, OP_SLTIU = 6'b001011,
        OP_ANDI    = 6'b001100, OP_ORI    = 6'b001101, OP_XORI  = 6'b001110,
        OP_LUI     = 6'b001111
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000, FN_SRL  = 6'b000010, FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100, FN_SRLV = 6'b000110, FN_SRAV = 6'b000111,
        FN_JR   = 6'b001000, FN_JALR = 6'b001001, FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001, FN_SUB  = 6'b100010, FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100, FN_OR   = 6'b100101, FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111, FN_SLT  = 6'b101010, FN_SLTU = 6'b101011
    } funct_e;

    typedef enum logic [4:0] {
        RI_BLTZ   = 5'b00000, RI_BGEZ   = 5'b00001,
        RI_BLTZAL = 5'b10000, RI_BGEZAL = 5'b10001
    } regimm_e;

    // shift ops are shared by the constant and variable forms
    typedef enum logic [7:0] {
        ALU_NOP    = 8'b00000000, ALU_AND    = 8'b00100100, ALU_OR     = 8'b00100101,
        ALU_XOR    = 8'b00100110, ALU_NOR    = 8'b00100111, ALU_ANDI   = 8'b01011001,
        ALU_ORI    = 8'b01011010, ALU_XORI   = 8'b01011011, ALU_LUI    = 8'b01011100,
        ALU_SLL    = 8'b01111100, ALU_SRL    = 8'b00000010, ALU_SRA    = 8'b00000011,
        ALU_ADD    = 8'b00100000, ALU_ADDU   = 8'b00100001, ALU_SUB    = 8'b00100010,
        ALU_SUBU   = 8'b00100011, ALU_SLT    = 8'b00101010, ALU_SLTU   = 8'b00101011,
        ALU_ADDI   = 8'b01010101, ALU_ADDIU  = 8'b01010110, ALU_SLTI   = 8'b01010111,
        ALU_SLTIU  = 8'b01011000, ALU_J      = 8'b01001111, ALU_JAL    = 8'b01010000,
        ALU_JR     = 8'b00001000, ALU_JALR   = 8'b00001001, ALU_BEQ    = 8'b01010001,
        ALU_BNE    = 8'b01010010, ALU_BGTZ   = 8'b01010100, ALU_BLEZ   = 8'b01010011,
        ALU_BLTZ   = 8'b01000000, ALU_BGEZ   = 8'b01000001, ALU_BLTZAL = 8'b01001010,
        ALU_BGEZAL = 8'b01001011
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000, SEL_LOGIC       = 3'b001, SEL_SHIFT = 3'b010,
        SEL_ARITH = 3'b100, SEL_JUMP_BRANCH = 3'b110
    } alu_sel_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_ALWAYS, BR_EQ, BR_NE, BR_GTZ, BR_LEZ, BR_LTZ, BR_GEZ
    } br_cond_e;

endpackage

/* src/regfile.sv */
`timescale 1ns/100ps
`include "dec_params.svh"

module regfile (
    input  logic               clk,
    input  logic               rst,
    input  logic               we_i,
    input  dec_pkg::reg_addr_t waddr_i,
    input  dec_pkg::word_t     wdata_i,
    input  dec_pkg::reg_addr_t raddr1_i,
    input  dec_pkg::reg_addr_t raddr2_i,
    output dec_pkg::word_t     rdata1_o,
    output dec_pkg::word_t     rdata2_o
);
    import dec_pkg::*;

    word_t regs [`DEC_NUM_REGS];
    logic  wr_en;

    assign wr_en = we_i && !rst && (waddr_i != '0);   // r0 is hardwired

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // same-cycle write-back is bypassed to the reader
    assign rdata1_o = (raddr1_i == '0) ? '0 :
                      (wr_en && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 :
                      (wr_en && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

    a_r0_reads_zero: assert property (@(posedge clk) raddr1_i == '0 |-> rdata1_o == '0);

endmodule

/* src/inst_decoder.sv */
`timescale 1ns/100ps
`include "dec_params.svh"

module inst_decoder (
    input  dec_pkg::word_t     inst_i,
    output dec_pkg::reg_addr_t raddr1_o,
    output dec_pkg::reg_addr_t raddr2_o,
    output logic               re1_o,
    output logic               re2_o,
    output dec_pkg::word_t     imm_o,
    output dec_pkg::alu_op_e   aluop_o,
    output dec_pkg::alu_sel_e  alusel_o,
    output dec_pkg::reg_addr_t wd_o,
    output logic               wreg_o,
    output dec_pkg::br_cond_e  br_cond_o,
    output logic               link_o
);
    import dec_pkg::*;

    opcode_e     opcode;
    funct_e      funct;
    reg_addr_t   rt;
    logic [4:0]  sa;
    logic [15:0] imm16;
    logic        fn_ok;

    assign opcode = opcode_e'(inst_i[31:26]);
    assign funct = funct_e'(inst_i[5:0]);
    assign rt = inst_i[20:16];
    assign sa = inst_i[10:6];
    assign imm16 = inst_i[15:0];
    assign raddr1_o = inst_i[25:21];
    assign raddr2_o = rt;
    // constant shifts need rs clear, other r-type forms need sa clear
    assign fn_ok = (inst_i[5:2] == 4'b0000) ? (raddr1_o == '0) : (sa == '0);

    always_comb begin
        re1_o = 1'b0;
        re2_o = 1'b0;
        imm_o = '0;
        aluop_o = ALU_NOP;
        alusel_o = SEL_NOP;
        wd_o = inst_i[15:11];   // rd by default
        wreg_o = 1'b0;
        br_cond_o = BR_NONE;
        link_o = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_AND:          aluop_o = ALU_AND;
                    FN_OR:           aluop_o = ALU_OR;
                    FN_XOR:          aluop_o = ALU_XOR;
                    FN_NOR:          aluop_o = ALU_NOR;
                    FN_SLL, FN_SLLV: aluop_o = ALU_SLL;
                    FN_SRL, FN_SRLV: aluop_o = ALU_SRL;
                    FN_SRA, FN_SRAV: aluop_o = ALU_SRA;
                    FN_ADD:          aluop_o = ALU_ADD;
                    FN_ADDU:         aluop_o = ALU_ADDU;
                    FN_SUB:          aluop_o = ALU_SUB;
                    FN_SUBU:         aluop_o = ALU_SUBU;
                    FN_SLT:          aluop_o = ALU_SLT;
                    FN_SLTU:         aluop_o = ALU_SLTU;
                    FN_JR:           aluop_o = ALU_JR;
                    FN_JALR:         aluop_o = ALU_JALR;
                    default:         aluop_o = ALU_NOP;
                endcase
                if (aluop_o != ALU_NOP && fn_ok) begin
                    re1_o = 1'b1;
                    re2_o = 1'b1;
                    wreg_o = 1'b1;
                    if (funct[5:2] == 4'b1001) begin
                        alusel_o = SEL_LOGIC;
                    end else if (funct[5]) begin
                        alusel_o = SEL_ARITH;
                    end else if (!funct[3]) begin
                        alusel_o = SEL_SHIFT;
                        if (!funct[2]) begin    // shift amount from sa
                            re1_o = 1'b0;
                            imm_o = word_t'(sa);
                        end
                    end else begin              // jr, jalr
                        alusel_o = SEL_JUMP_BRANCH;
                        re2_o = 1'b0;
                        wreg_o = funct[0];
                        link_o = funct[0];
                        br_cond_o = BR_ALWAYS;
                    end
                end else begin
                    aluop_o = ALU_NOP;
                end
            end
            OP_REGIMM: begin
                case (regimm_e'(rt))
                    RI_BLTZ:   aluop_o = ALU_BLTZ;
                    RI_BGEZ:   aluop_o = ALU_BGEZ;
                    RI_BLTZAL: aluop_o = ALU_BLTZAL;
                    RI_BGEZAL: aluop_o = ALU_BGEZAL;
                    default:   aluop_o = ALU_NOP;
                endcase
                if (aluop_o != ALU_NOP) begin
                    re1_o = 1'b1;
                    alusel_o = SEL_JUMP_BRANCH;
                    br_cond_o = rt[0] ? BR_GEZ : BR_LTZ;
                    wreg_o = rt[4];             // al forms
                    link_o = rt[4];
                    wd_o = reg_addr_t'(`DEC_LINK_REG);
                end
            end
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                re1_o = 1'b1;
                wreg_o = 1'b1;
                wd_o = rt;
                alusel_o = SEL_LOGIC;
                imm_o = (opcode == OP_LUI) ? {imm16, 16'h0000} : {16'h0000, imm16};
                case (opcode)
                    OP_ANDI: aluop_o = ALU_ANDI;
                    OP_ORI:  aluop_o = ALU_ORI;
                    OP_XORI: aluop_o = ALU_XORI;
                    default: aluop_o = ALU_LUI;
                endcase
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
                re1_o = 1'b1;
                wreg_o = 1'b1;
                wd_o = rt;
                alusel_o = SEL_ARITH;
                imm_o = {{16{imm16[15]}}, imm16};
                case (opcode)
                    OP_ADDI:  aluop_o = ALU_ADDI;
                    OP_ADDIU: aluop_o = ALU_ADDIU;
                    OP_SLTI:  aluop_o = ALU_SLTI;
                    default:  aluop_o = ALU_SLTIU;
                endcase
            end
            OP_J, OP_JAL: begin
                alusel_o = SEL_JUMP_BRANCH;
                aluop_o = opcode[0] ? ALU_JAL : ALU_J;
                br_cond_o = BR_ALWAYS;
                wreg_o = opcode[0];
                link_o = opcode[0];
                wd_o = reg_addr_t'(`DEC_LINK_REG);
            end
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
                re1_o = 1'b1;
                re2_o = !opcode[1];             // only beq/bne read rt
                alusel_o = SEL_JUMP_BRANCH;
                case (opcode)
                    OP_BEQ:  aluop_o = ALU_BEQ;
                    OP_BNE:  aluop_o = ALU_BNE;
                    OP_BLEZ: aluop_o = ALU_BLEZ;
                    default: aluop_o = ALU_BGTZ;
                endcase
                case (opcode)
                    OP_BEQ:  br_cond_o = BR_EQ;
                    OP_BNE:  br_cond_o = BR_NE;
                    OP_BLEZ: br_cond_o = BR_LEZ;
                    default: br_cond_o = BR_GTZ;
                endcase
            end
            default: ;
        endcase
    end

    a_nop_no_write: assert final (alusel_o != SEL_NOP || !wreg_o);

endmodule

/* src/operand_forward.sv */
`timescale 1ns/100ps

module operand_forward (
    input  logic               re_i,
    input  dec_pkg::reg_addr_t raddr_i,
    input  dec_pkg::word_t     imm_i,
    input  dec_pkg::word_t     rf_data_i,
    input  logic               ex_wreg_i,
    input  dec_pkg::reg_addr_t ex_wd_i,
    input  dec_pkg::word_t     ex_wdata_i,
    input  logic               mem_wreg_i,
    input  dec_pkg::reg_addr_t mem_wd_i,
    input  dec_pkg::word_t     mem_wdata_i,
    output dec_pkg::word_t     opnd_o
);

    logic ex_hit;
    logic mem_hit;

    // writes to r0 are never forwarded
    assign ex_hit = ex_wreg_i && (ex_wd_i == raddr_i) && (ex_wd_i != '0);
    assign mem_hit = mem_wreg_i && (mem_wd_i == raddr_i) && (mem_wd_i != '0);

    always_comb begin
        if (!re_i) begin
            opnd_o = imm_i;
        end else if (ex_hit) begin      // youngest result wins
            opnd_o = ex_wdata_i;
        end else if (mem_hit) begin
            opnd_o = mem_wdata_i;
        end else begin
            opnd_o = rf_data_i;
        end
    end

endmodule

/* src/branch_unit.sv */
`timescale 1ns/100ps

module branch_unit (
    input  dec_pkg::word_t    pc_i,
    input  dec_pkg::word_t    inst_i,
    input  dec_pkg::br_cond_e br_cond_i,
    input  logic              link_i,
    input  dec_pkg::word_t    opnd1_i,
    input  dec_pkg::word_t    opnd2_i,
    output logic              taken_o,
    output dec_pkg::word_t    target_o,
    output dec_pkg::word_t    link_addr_o
);
    import dec_pkg::*;

    word_t pc_plus4;
    word_t br_offset;
    word_t target;
    logic  is_jtype;

    assign pc_plus4 = pc_i + 32'd4;
    assign br_offset = {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
    assign is_jtype = opcode_e'(inst_i[31:26]) inside {OP_J, OP_JAL};

    always_comb begin
        case (br_cond_i)
            BR_ALWAYS: taken_o = 1'b1;
            BR_EQ:     taken_o = (opnd1_i == opnd2_i);
            BR_NE:     taken_o = (opnd1_i != opnd2_i);
            BR_GTZ:    taken_o = !opnd1_i[31] && (opnd1_i != '0);
            BR_LEZ:    taken_o = opnd1_i[31] || (opnd1_i == '0);
            BR_LTZ:    taken_o = opnd1_i[31];
            BR_GEZ:    taken_o = !opnd1_i[31];
            default:   taken_o = 1'b0;
        endcase
    end

    always_comb begin
        if (br_cond_i != BR_ALWAYS) begin
            target = pc_plus4 + br_offset;
        end else if (is_jtype) begin
            target = {pc_plus4[31:28], inst_i[25:0], 2'b00};    // same 256MB region
        end else begin
            target = opnd1_i;   // jr, jalr
        end
    end

    assign target_o = taken_o ? target : '0;
    assign link_addr_o = link_i ? pc_i + 32'd8 : '0;   // skip the delay slot

endmodule

/* src/id_ex_reg.sv */
`timescale 1ns/100ps

module id_ex_reg (
    input  logic               clk,
    input  logic               rst,
    input  logic               taken_i,
    input  dec_pkg::alu_op_e   aluop_i,
    input  dec_pkg::alu_sel_e  alusel_i,
    input  dec_pkg::reg_addr_t wd_i,
    input  logic               wreg_i,
    input  dec_pkg::word_t     reg1_i,
    input  dec_pkg::word_t     reg2_i,
    input  dec_pkg::word_t     link_addr_i,
    output dec_pkg::alu_op_e   aluop_o,
    output dec_pkg::alu_sel_e  alusel_o,
    output dec_pkg::reg_addr_t wd_o,
    output logic               wreg_o,
    output dec_pkg::word_t     reg1_o,
    output dec_pkg::word_t     reg2_o,
    output dec_pkg::word_t     link_addr_o,
    output logic               in_delayslot_o
);
    import dec_pkg::*;

    logic next_in_delayslot;    // instruction now in decode sits in the slot

    always_ff @(posedge clk) begin
        if (rst) begin
            aluop_o <= ALU_NOP;
            alusel_o <= SEL_NOP;
            wreg_o <= 1'b0;
            next_in_delayslot <= 1'b0;
            in_delayslot_o <= 1'b0;
        end else begin
            aluop_o <= aluop_i;
            alusel_o <= alusel_i;
            wreg_o <= wreg_i;
            next_in_delayslot <= taken_i;
            in_delayslot_o <= next_in_delayslot;
        end
    end

    always_ff @(posedge clk) begin
        wd_o <= wd_i;
        reg1_o <= reg1_i;
        reg2_o <= reg2_i;
        link_addr_o <= link_addr_i;
    end

    a_rst_no_write: assert property (@(posedge clk) rst |=> !wreg_o);

endmodule

/* src/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage (
    input  logic               clk,
    input  logic               rst,
    input  dec_pkg::word_t     pc_i,
    input  dec_pkg::word_t     inst_i,
    input  logic               wb_we_i,
    input  dec_pkg::reg_addr_t wb_addr_i,
    input  dec_pkg::word_t     wb_data_i,
    input  logic               ex_wreg_i,
    input  dec_pkg::reg_addr_t ex_wd_i,
    input  dec_pkg::word_t     ex_wdata_i,
    input  logic               mem_wreg_i,
    input  dec_pkg::reg_addr_t mem_wd_i,
    input  dec_pkg::word_t     mem_wdata_i,
    output logic               branch_flag_o,
    output dec_pkg::word_t     branch_target_o,
    output dec_pkg::alu_op_e   aluop_o,
    output dec_pkg::alu_sel_e  alusel_o,
    output dec_pkg::reg_addr_t wd_o,
    output logic               wreg_o,
    output dec_pkg::word_t     reg1_o,
    output dec_pkg::word_t     reg2_o,
    output dec_pkg::word_t     link_addr_o,
    output logic               in_delayslot_o
);
    import dec_pkg::*;

    reg_addr_t raddr1;
    reg_addr_t raddr2;
    logic      re1;
    logic      re2;
    word_t     imm;
    word_t     rf_data1;
    word_t     rf_data2;
    alu_op_e   dec_aluop;
    alu_sel_e  dec_alusel;
    reg_addr_t dec_wd;
    logic      dec_wreg;
    br_cond_e  br_cond;
    logic      link;
    word_t     opnd1;
    word_t     opnd2;
    word_t     link_addr;

    regfile u_regfile (
        .clk(clk), .rst(rst),
        .we_i(wb_we_i), .waddr_i(wb_addr_i), .wdata_i(wb_data_i),
        .raddr1_i(raddr1), .raddr2_i(raddr2),
        .rdata1_o(rf_data1), .rdata2_o(rf_data2)
    );

    inst_decoder u_inst_decoder (
        .inst_i(inst_i),
        .raddr1_o(raddr1), .raddr2_o(raddr2),
        .re1_o(re1), .re2_o(re2), .imm_o(imm),
        .aluop_o(dec_aluop), .alusel_o(dec_alusel),
        .wd_o(dec_wd), .wreg_o(dec_wreg),
        .br_cond_o(br_cond), .link_o(link)
    );

    operand_forward u_fwd_rs (
        .re_i(re1), .raddr_i(raddr1), .imm_i(imm), .rf_data_i(rf_data1),
        .ex_wreg_i(ex_wreg_i), .ex_wd_i(ex_wd_i), .ex_wdata_i(ex_wdata_i),
        .mem_wreg_i(mem_wreg_i), .mem_wd_i(mem_wd_i), .mem_wdata_i(mem_wdata_i),
        .opnd_o(opnd1)
    );

    operand_forward u_fwd_rt (
        .re_i(re2), .raddr_i(raddr2), .imm_i(imm), .rf_data_i(rf_data2),
        .ex_wreg_i(ex_wreg_i), .ex_wd_i(ex_wd_i), .ex_wdata_i(ex_wdata_i),
        .mem_wreg_i(mem_wreg_i), .mem_wd_i(mem_wd_i), .mem_wdata_i(mem_wdata_i),
        .opnd_o(opnd2)
    );

    branch_unit u_branch_unit (
        .pc_i(pc_i), .inst_i(inst_i), .br_cond_i(br_cond), .link_i(link),
        .opnd1_i(opnd1), .opnd2_i(opnd2),
        .taken_o(branch_flag_o), .target_o(branch_target_o),
        .link_addr_o(link_addr)
    );

    id_ex_reg u_id_ex_reg (
        .clk(clk), .rst(rst), .taken_i(branch_flag_o),
        .aluop_i(dec_aluop), .alusel_i(dec_alusel),
        .wd_i(dec_wd), .wreg_i(dec_wreg),
        .reg1_i(opnd1), .reg2_i(opnd2), .link_addr_i(link_addr),
        .aluop_o(aluop_o), .alusel_o(alusel_o),
        .wd_o(wd_o), .wreg_o(wreg_o),
        .reg1_o(reg1_o), .reg2_o(reg2_o), .link_addr_o(link_addr_o),
        .in_delayslot_o(in_delayslot_o)
    );

endmodule

/* verif/decode_model.svh */
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// immediate operand by instruction kind
function automatic word_t ext_imm(alu_op_e op, word_t inst);
    case (op)
        ALU_ANDI, ALU_ORI, ALU_XORI: return {16'h0000, inst[15:0]};
        ALU_LUI: return {inst[15:0], 16'h0000};
        ALU_ADDI, ALU_ADDIU, ALU_SLTI, ALU_SLTIU: return {{16{inst[15]}}, inst[15:0]};
        ALU_SLL, ALU_SRL, ALU_SRA: return inst[2] ? 32'd0 : {27'd0, inst[10:6]};  // sa form
        default: return '0;
    endcase
endfunction

function automatic logic reads_rs(alu_op_e op, word_t inst);
    if (op inside {ALU_NOP, ALU_J, ALU_JAL}) return 1'b0;
    return !(op inside {ALU_SLL, ALU_SRL, ALU_SRA} && !inst[2]);
endfunction

function automatic logic reads_rt(alu_op_e op, word_t inst);
    if (op inside {ALU_BEQ, ALU_BNE}) return 1'b1;
    return (inst[31:26] == 6'd0) && !(op inside {ALU_JR, ALU_JALR});
endfunction

// execute beats memory beats register file, r0 never forwarded
function automatic word_t fwd_operand(logic re, reg_addr_t ra, word_t imm, word_t rf_val,
                                      logic ex_we, reg_addr_t ex_wd, word_t ex_d,
                                      logic mem_we, reg_addr_t mem_wd, word_t mem_d);
    if (!re) return imm;
    if (ex_we && ex_wd == ra && ra != 0) return ex_d;
    if (mem_we && mem_wd == ra && ra != 0) return mem_d;
    return (ra == 0) ? 32'd0 : rf_val;
endfunction

function automatic logic branch_taken(alu_op_e op, word_t a, word_t b);
    case (op)
        ALU_J, ALU_JAL, ALU_JR, ALU_JALR: return 1'b1;
        ALU_BEQ: return a == b;
        ALU_BNE: return a != b;
        ALU_BGTZ: return $signed(a) > 0;
        ALU_BLEZ: return $signed(a) <= 0;
        ALU_BLTZ, ALU_BLTZAL: return $signed(a) < 0;
        ALU_BGEZ, ALU_BGEZAL: return $signed(a) >= 0;
        default: return 1'b0;
    endcase
endfunction

function automatic word_t branch_dest(alu_op_e op, word_t inst, word_t pc, word_t a);
    word_t pc4;
    pc4 = pc + 32'd4;
    if (op inside {ALU_J, ALU_JAL}) return {pc4[31:28], inst[25:0], 2'b00};
    if (op inside {ALU_JR, ALU_JALR}) return a;
    return pc4 + {{14{inst[15]}}, inst[15:0], 2'b00};
endfunction

function automatic word_t link_of(alu_op_e op, word_t pc);
    return (op inside {ALU_JAL, ALU_JALR, ALU_BLTZAL, ALU_BGEZAL}) ? pc + 32'd8 : 32'd0;
endfunction

`endif

/* verif/tb_decode_stage.sv */
`timescale 1ns/100ps
`include "dec_params.svh"

module tb_decode_stage;
    import dec_pkg::*;

    `include "decode_model.svh"

    typedef struct packed {
        word_t     inst;
        alu_op_e   op;
        alu_sel_e  sel;
        reg_addr_t wd;
        logic      wreg;
        logic      ex_we;
        reg_addr_t ex_wd;
        word_t     ex_d;
        logic      mem_we;
        reg_addr_t mem_wd;
        word_t     mem_d;
        logic      wb_we;
        reg_addr_t wb_addr;
        word_t     wb_d;
    } vec_t;

    typedef struct packed {
        word_t reg1;
        word_t reg2;
        logic  taken;
        word_t target;
        word_t link;
        logic  ds;
    } exp_t;

    logic      clk = 1'b0;
    logic      rst;
    word_t     pc_i;
    word_t     inst_i;
    logic      wb_we_i;
    reg_addr_t wb_addr_i;
    word_t     wb_data_i;
    logic      ex_wreg_i;
    reg_addr_t ex_wd_i;
    word_t     ex_wdata_i;
    logic      mem_wreg_i;
    reg_addr_t mem_wd_i;
    word_t     mem_wdata_i;
    logic      branch_flag_o;
    word_t     branch_target_o;
    alu_op_e   aluop_o;
    alu_sel_e  alusel_o;
    reg_addr_t wd_o;
    logic      wreg_o;
    word_t     reg1_o;
    word_t     reg2_o;
    word_t     link_addr_o;
    logic      in_delayslot_o;

    vec_t  tbl [$];
    exp_t  expq [$];
    word_t rf_model [`DEC_NUM_REGS];
    int    test_err [64];
    int    tests_failed = 0;
    int    seed;
    int    cycles = 0;
    int    limit = 0;

    decode_stage UUT (.*);

    always #50 clk = ~clk;

    function automatic word_t r_inst(funct_e fn, int rs, int rt, int rd, int sa);
        return {6'b000000, reg_addr_t'(rs), reg_addr_t'(rt), reg_addr_t'(rd), reg_addr_t'(sa), fn};
    endfunction

    function automatic word_t i_inst(opcode_e op, int rs, int rt, logic [15:0] imm);
        return {op, reg_addr_t'(rs), reg_addr_t'(rt), imm};
    endfunction

    task automatic compare_word(int t, string what, word_t got, word_t exp);
        if (got !== exp) begin
            $display("Fail %0t: test %0d %s is %h, expected %h", $time, t, what, got, exp);
            test_err[t]++;
        end
    endtask

    task automatic compare_flag(int t, string what, logic got, logic exp);
        if (got !== exp) begin
            $display("Fail %0t: test %0d %s is %b, expected %b", $time, t, what, got, exp);
            test_err[t]++;
        end
    endtask

    task automatic compare_ctrl(int t, alu_op_e got_op, alu_op_e exp_op,
                                alu_sel_e got_sel, alu_sel_e exp_sel);
        if (got_op !== exp_op || got_sel !== exp_sel) begin
            $display("Fail %0t: test %0d aluop/alusel is %h/%h, expected %h/%h",
                     $time, t, got_op, got_sel, exp_op, exp_sel);
            test_err[t]++;
        end
    endtask

    task automatic report_test(int t, string name);
        if (test_err[t] == 0) begin
            $display("test %0d %s: pass", t, name);
        end else begin
            $display("test %0d %s: fail, %0d mismatches", t, name, test_err[t]);
            tests_failed++;
        end
    endtask

    task automatic push_row(word_t inst, alu_op_e op, alu_sel_e sel, int wd, logic wreg);
        vec_t v;
        v = '0;
        v.inst = inst;
        v.op = op;
        v.sel = sel;
        v.wd = reg_addr_t'(wd);
        v.wreg = wreg;
        tbl.push_back(v);
    endtask

    // forwarding and write-back fields of the last row
    task automatic forward_to(logic ex_we, int ex_wd, word_t ex_d,
                              logic mem_we, int mem_wd, word_t mem_d, int wb_addr, word_t wb_d);
        vec_t v;
        v = tbl.pop_back();
        v.ex_we = ex_we;
        v.ex_wd = reg_addr_t'(ex_wd);
        v.ex_d = ex_d;
        v.mem_we = mem_we;
        v.mem_wd = reg_addr_t'(mem_wd);
        v.mem_d = mem_d;
        v.wb_we = (wb_addr != 0);
        v.wb_addr = reg_addr_t'(wb_addr);
        v.wb_d = wb_d;
        tbl.push_back(v);
    endtask

    // rs value comes over the execute bus, rt over the memory bus
    task automatic branch_row(word_t inst, alu_op_e op, int wd, logic wreg, word_t a, word_t b);
        push_row(inst, op, SEL_JUMP_BRANCH, wd, wreg);
        forward_to(1'b1, inst[25:21], a, 1'b1, inst[20:16], b, 0, '0);
    endtask

    task automatic build_table();
        push_row(r_inst(FN_AND, 1, 2, 3, 0), ALU_AND, SEL_LOGIC, 3, 1'b1);
        push_row(r_inst(FN_NOR, 4, 5, 6, 0), ALU_NOR, SEL_LOGIC, 6, 1'b1);
        push_row(r_inst(FN_SLL, 0, 8, 7, 5), ALU_SLL, SEL_SHIFT, 7, 1'b1);
        push_row(r_inst(FN_SRAV, 10, 11, 9, 0), ALU_SRA, SEL_SHIFT, 9, 1'b1);
        push_row(r_inst(FN_SUBU, 12, 13, 14, 0), ALU_SUBU, SEL_ARITH, 14, 1'b1);
        push_row(r_inst(FN_SLT, 15, 16, 17, 0), ALU_SLT, SEL_ARITH, 17, 1'b1);
        push_row(i_inst(OP_ANDI, 18, 19, 16'h8001), ALU_ANDI, SEL_LOGIC, 19, 1'b1);
        push_row(i_inst(OP_LUI, 0, 20, 16'habcd), ALU_LUI, SEL_LOGIC, 20, 1'b1);
        push_row(i_inst(OP_ADDI, 21, 22, 16'hfff0), ALU_ADDI, SEL_ARITH, 22, 1'b1);
        push_row(i_inst(OP_SLTIU, 23, 24, 16'h7fff), ALU_SLTIU, SEL_ARITH, 24, 1'b1);
        push_row(r_inst(FN_ADDU, 2, 3, 1, 0), ALU_ADDU, SEL_ARITH, 1, 1'b1);
        forward_to(1'b1, 2, 32'h1111_1111, 1'b1, 2, 32'h2222_2222, 0, '0);
        push_row(r_inst(FN_ADDU, 2, 3, 1, 0), ALU_ADDU, SEL_ARITH, 1, 1'b1);
        forward_to(1'b0, 2, 32'h1111_1111, 1'b1, 2, 32'h2222_2222, 0, '0);
        push_row(r_inst(FN_OR, 0, 5, 4, 0), ALU_OR, SEL_LOGIC, 4, 1'b1);
        forward_to(1'b1, 0, 32'hdead_beef, 1'b1, 0, 32'hdead_beef, 0, '0);
        push_row(i_inst(OP_ORI, 21, 25, 16'h0000), ALU_ORI, SEL_LOGIC, 25, 1'b1);
        forward_to(1'b0, 0, '0, 1'b0, 0, '0, 21, 32'h5a5a_0f0f);     // same-cycle bypass
        push_row(r_inst(FN_XOR, 21, 0, 26, 0), ALU_XOR, SEL_LOGIC, 26, 1'b1);
        branch_row(i_inst(OP_BEQ, 1, 2, 16'hfffc), ALU_BEQ, 0, 1'b0, 32'd5, 32'd5);
        branch_row(i_inst(OP_BEQ, 1, 2, 16'h0010), ALU_BEQ, 0, 1'b0, 32'd5, 32'd6);
        branch_row(i_inst(OP_BNE, 1, 2, 16'h0010), ALU_BNE, 0, 1'b0, 32'd5, 32'd6);
        branch_row(i_inst(OP_BNE, 1, 2, 16'hfff0), ALU_BNE, 0, 1'b0, 32'd7, 32'd7);
        branch_row(i_inst(OP_BGTZ, 3, 0, 16'h0020), ALU_BGTZ, 0, 1'b0, 32'd1, '0);
        branch_row(i_inst(OP_BGTZ, 3, 0, 16'h0020), ALU_BGTZ, 0, 1'b0, 32'd0, '0);
        branch_row(i_inst(OP_BLEZ, 4, 0, 16'hff00), ALU_BLEZ, 0, 1'b0, 32'd0, '0);
        branch_row(i_inst(OP_BLEZ, 4, 0, 16'hff00), ALU_BLEZ, 0, 1'b0, 32'd1, '0);
        branch_row(i_inst(OP_REGIMM, 5, RI_BLTZ, 16'h0004), ALU_BLTZ, 0, 1'b0, 32'h8000_0000, '0);
        branch_row(i_inst(OP_REGIMM, 5, RI_BLTZ, 16'h0004), ALU_BLTZ, 0, 1'b0, 32'd0, '0);
        branch_row(i_inst(OP_REGIMM, 6, RI_BGEZ, 16'h0040), ALU_BGEZ, 0, 1'b0, 32'd0, '0);
        branch_row(i_inst(OP_REGIMM, 6, RI_BGEZ, 16'h0040), ALU_BGEZ, 0, 1'b0, 32'hffff_ffff, '0);
        branch_row(i_inst(OP_REGIMM, 7, RI_BLTZAL, 16'h0008), ALU_BLTZAL, 31, 1'b1, -32'sd1, '0);
        branch_row(i_inst(OP_REGIMM, 7, RI_BGEZAL, 16'h0008), ALU_BGEZAL, 31, 1'b1, -32'sd1, '0);
        branch_row({OP_J, 26'h0123456}, ALU_J, 0, 1'b0, '0, '0);
        branch_row({OP_JAL, 26'h0000040}, ALU_JAL, 31, 1'b1, '0, '0);
        branch_row(r_inst(FN_JR, 9, 0, 0, 0), ALU_JR, 0, 1'b0, 32'h0040_1234, '0);
        branch_row(r_inst(FN_JALR, 9, 0, 10, 0), ALU_JALR, 10, 1'b1, 32'h0040_2000, '0);
        push_row(i_inst(OP_ADDIU, 11, 12, 16'h0001), ALU_ADDIU, SEL_ARITH, 12, 1'b1);
    endtask

    task automatic apply_vec(int i, logic last_taken);
        vec_t      v;
        exp_t      e;
        word_t     pc;
        word_t     imm;
        reg_addr_t rs;
        reg_addr_t rt;
        v = tbl[i];
        pc = 32'h1000_0000 + i * 4;
        rs = v.inst[25:21];
        rt = v.inst[20:16];
        if (v.wb_we) begin
            rf_model[v.wb_addr] = v.wb_d;
        end
        imm = ext_imm(v.op, v.inst);
        e.reg1 = fwd_operand(reads_rs(v.op, v.inst), rs, imm, rf_model[rs],
                             v.ex_we, v.ex_wd, v.ex_d, v.mem_we, v.mem_wd, v.mem_d);
        e.reg2 = fwd_operand(reads_rt(v.op, v.inst), rt, imm, rf_model[rt],
                             v.ex_we, v.ex_wd, v.ex_d, v.mem_we, v.mem_wd, v.mem_d);
        e.taken = branch_taken(v.op, e.reg1, e.reg2);
        e.target = e.taken ? branch_dest(v.op, v.inst, pc, e.reg1) : 32'd0;
        e.link = link_of(v.op, pc);
        e.ds = last_taken;
        expq.push_back(e);
        pc_i <= pc;
        inst_i <= v.inst;
        wb_we_i <= v.wb_we;
        wb_addr_i <= v.wb_addr;
        wb_data_i <= v.wb_d;
        ex_wreg_i <= v.ex_we;
        ex_wd_i <= v.ex_wd;
        ex_wdata_i <= v.ex_d;
        mem_wreg_i <= v.mem_we;
        mem_wd_i <= v.mem_wd;
        mem_wdata_i <= v.mem_d;
    endtask

    task automatic check_stage(int i);
        vec_t v;
        exp_t e;
        v = tbl[i];
        e = expq[i];
        compare_ctrl(i + 1, aluop_o, v.op, alusel_o, v.sel);
        compare_flag(i + 1, "wreg_o", wreg_o, v.wreg);
        if (v.wreg) begin
            compare_word(i + 1, "wd_o", word_t'(wd_o), word_t'(v.wd));
        end
        compare_word(i + 1, "reg1_o", reg1_o, e.reg1);
        compare_word(i + 1, "reg2_o", reg2_o, e.reg2);
        compare_word(i + 1, "link_addr_o", link_addr_o, e.link);
        compare_flag(i + 1, "in_delayslot_o", in_delayslot_o, e.ds);
        report_test(i + 1, v.op.name());
    endtask

    initial begin
        word_t d;
        seed = 36340;
        rst = 1'b1;
        pc_i = '0;
        inst_i = {OP_JAL, 26'h0000100};     // taken jal held through reset
        wb_we_i = 1'b0;
        wb_addr_i = '0;
        wb_data_i = '0;
        ex_wreg_i = 1'b0;
        ex_wd_i = '0;
        ex_wdata_i = '0;
        mem_wreg_i = 1'b0;
        mem_wd_i = '0;
        mem_wdata_i = '0;
        build_table();
        limit = 2 * (tbl.size() + `DEC_NUM_REGS) + 20;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        inst_i <= '0;
        @(negedge clk);
        compare_flag(0, "wreg_o", wreg_o, 1'b0);
        compare_flag(0, "in_delayslot_o", in_delayslot_o, 1'b0);
        compare_flag(0, "branch_flag_o", branch_flag_o, 1'b0);
        compare_ctrl(0, aluop_o, ALU_NOP, alusel_o, SEL_NOP);
        report_test(0, "reset");
        rf_model[0] = '0;
        for (int r = 1; r < `DEC_NUM_REGS; r++) begin     // preload through write-back
            d = $random(seed);
            rf_model[r] = d;
            @(posedge clk);
            wb_we_i <= 1'b1;
            wb_addr_i <= reg_addr_t'(r);
            wb_data_i <= d;
        end
        for (int i = 0; i <= tbl.size(); i++) begin
            @(posedge clk);
            if (i < tbl.size()) begin
                apply_vec(i, (i > 0) ? expq[i - 1].taken : 1'b0);
            end else begin
                inst_i <= '0;
                wb_we_i <= 1'b0;
                ex_wreg_i <= 1'b0;
                mem_wreg_i <= 1'b0;
            end
            @(negedge clk);
            if (i < tbl.size()) begin   // combinational branch outputs
                compare_flag(i + 1, "branch_flag_o", branch_flag_o, expq[i].taken);
                compare_word(i + 1, "branch_target_o", branch_target_o, expq[i].target);
            end
            if (i > 0) begin
                check_stage(i - 1);
            end
        end
        $display("%0d tests passed, %0d tests failed", tbl.size() + 1 - tests_failed,
                 tests_failed);
        if (tests_failed == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* files.f */
+incdir+src
+incdir+verif
src/dec_pkg.sv
src/regfile.sv
src/inst_decoder.sv
src/operand_forward.sv
src/branch_unit.sv
src/id_ex_reg.sv
src/decode_stage.sv
verif/tb_decode_stage.sv

/* Bender.yml */
package:
  name: decode_stage

sources:
  - include_dirs:
      - src
    files:
      - src/dec_pkg.sv
      - src/regfile.sv
      - src/inst_decoder.sv
      - src/operand_forward.sv
      - src/branch_unit.sv
      - src/id_ex_reg.sv
      - src/decode_stage.sv
  - target: simulation
    include_dirs:
      - src
      - verif
    files:
      - verif/tb_decode_stage.sv
